//--- hdl/robotCfgPkg.sv
package robotCfgPkg;

	// ------------------------------
	// Types
	// ------------------------------

	// Servo setpoint in percent, 0 to 200 for full throw
	typedef logic [7:0] percent_t;

	// Width or frame count in OSC_FPGA cycles
	typedef logic [31:0] pulseWidth_t;

	// Free running encoder count
	typedef logic [31:0] encCount_t;

	// ------------------------------
	// Servo timing
	// ------------------------------

	// 22 ms frame at 50 MHz
	localparam logic [31:0] framePeriodCycles = 32'd1100000;
	// 1.0 ms pulse at percent 0
	localparam logic [31:0] pulseLowLimit = 32'd50000;
	// 0.5 ms spread over 100 percent
	localparam logic [31:0] pulseRangeStep = 32'd250;
	// Rest position, motors stopped
	localparam logic [31:0] centerPercent = 32'd100;
	// Width for the rest setpoint, 1.5 ms
	localparam pulseWidth_t pulseRestWidth = pulseLowLimit + centerPercent * pulseRangeStep;

	// Encoder start at mid range so it never wraps in normal use
	localparam encCount_t encResetCount = 32'h80000000;

endpackage

//--- hdl/robotRegPkg.sv
package robotRegPkg;

	// ------------------------------
	// Bus widths
	// ------------------------------
	typedef logic [31:0] regWord_t;
	typedef logic [7:0] apbAddr_t;

	// ------------------------------
	// Register map, byte addresses
	// ------------------------------
	typedef enum apbAddr_t {
		CTRL        = 8'h00,
		LEFT_SPEED  = 8'h04,
		RIGHT_SPEED = 8'h08,
		PAN_POS     = 8'h0C,
		TILT_POS    = 8'h10,
		// Read only from here on
		ENC_LEFT    = 8'h14,
		ENC_RIGHT   = 8'h18,
		BOARD_ID    = 8'h1C
	} regAddr_e;

	// CTRL layout
	localparam int ctrlBits = 3;
	localparam logic [31:0] ctrlMotorSelBit = 32'd0;
	localparam logic [31:0] ctrlCamSelBit = 32'd1;
	localparam logic [31:0] ctrlAlarmBit = 32'd2;
	// Both selects on RC passthrough, alarm off
	localparam logic [ctrlBits-1:0] ctrlResetValue = '0;

	// Identification word returned to the host
	localparam regWord_t boardIdWord = 32'hDEADBEEF;

endpackage

//--- hdl/hostRegs.sv
`timescale 1ns/1ps

module hostRegs (
	input  logic                   OSC_FPGA,
	input  logic                   arstN_i,
	// APB slave
	input  logic                   psel_i,
	input  logic                   penable_i,
	input  logic                   pwrite_i,
	input  robotRegPkg::apbAddr_t  paddr_i,
	input  robotRegPkg::regWord_t  pwdata_i,
	output robotRegPkg::regWord_t  prdata_o,
	output logic                   pready_o,
	output logic                   pslverr_o,
	// Live encoder counts
	input  robotCfgPkg::encCount_t encLeft_i,
	input  robotCfgPkg::encCount_t encRight_i,
	// Setpoints to the servo channels
	output robotCfgPkg::percent_t  leftSpeed_o,
	output robotCfgPkg::percent_t  rightSpeed_o,
	output robotCfgPkg::percent_t  panPos_o,
	output robotCfgPkg::percent_t  tiltPos_o,
	output logic                   motorSel_o,
	output logic                   camSel_o,
	output logic                   alarm_o
);

	logic [robotRegPkg::ctrlBits-1:0] ctrlReg;
	robotCfgPkg::percent_t leftSpeedReg;
	robotCfgPkg::percent_t rightSpeedReg;
	robotCfgPkg::percent_t panPosReg;
	robotCfgPkg::percent_t tiltPosReg;

	robotRegPkg::regAddr_e addrSel;
	robotRegPkg::regWord_t readData;
	logic accessPhase;
	logic addrKnown;
	logic addrReadOnly;
	logic writeEn;

	// ------------------------------
	// Address decode
	// ------------------------------
	assign addrSel = robotRegPkg::regAddr_e'(paddr_i);

	always_comb
	begin
		addrKnown = 1'b1;
		addrReadOnly = 1'b0;
		readData = '0;
		case (addrSel)
			robotRegPkg::CTRL:
				readData = robotRegPkg::regWord_t'(ctrlReg);
			robotRegPkg::LEFT_SPEED:
				readData = robotRegPkg::regWord_t'(leftSpeedReg);
			robotRegPkg::RIGHT_SPEED:
				readData = robotRegPkg::regWord_t'(rightSpeedReg);
			robotRegPkg::PAN_POS:
				readData = robotRegPkg::regWord_t'(panPosReg);
			robotRegPkg::TILT_POS:
				readData = robotRegPkg::regWord_t'(tiltPosReg);
			robotRegPkg::ENC_LEFT:
			begin
				readData = encLeft_i;
				addrReadOnly = 1'b1;
			end
			robotRegPkg::ENC_RIGHT:
			begin
				readData = encRight_i;
				addrReadOnly = 1'b1;
			end
			robotRegPkg::BOARD_ID:
			begin
				readData = robotRegPkg::boardIdWord;
				addrReadOnly = 1'b1;
			end
			// Hole in the map
			default:
				addrKnown = 1'b0;
		endcase
	end

	// Zero wait states
	assign accessPhase = psel_i & penable_i;
	assign pready_o = accessPhase;
	assign prdata_o = readData;
	// Bad address, or a write aimed at a read only word
	assign pslverr_o = accessPhase & (~addrKnown | (pwrite_i & addrReadOnly));
	assign writeEn = accessPhase & pwrite_i & addrKnown & ~addrReadOnly;

	// ------------------------------
	// Writable registers
	// ------------------------------
	always_ff @(posedge OSC_FPGA or negedge arstN_i)
	begin
		if (!arstN_i)
		begin
			ctrlReg <= robotRegPkg::ctrlResetValue;
			leftSpeedReg <= robotCfgPkg::percent_t'(robotCfgPkg::centerPercent);
			rightSpeedReg <= robotCfgPkg::percent_t'(robotCfgPkg::centerPercent);
			panPosReg <= robotCfgPkg::percent_t'(robotCfgPkg::centerPercent);
			tiltPosReg <= robotCfgPkg::percent_t'(robotCfgPkg::centerPercent);
		end
		else if (writeEn)
		begin
			// Upper bits of the bus word are dropped
			case (addrSel)
				robotRegPkg::CTRL:
					ctrlReg <= pwdata_i[robotRegPkg::ctrlBits-1:0];
				robotRegPkg::LEFT_SPEED:
					leftSpeedReg <= robotCfgPkg::percent_t'(pwdata_i);
				robotRegPkg::RIGHT_SPEED:
					rightSpeedReg <= robotCfgPkg::percent_t'(pwdata_i);
				robotRegPkg::PAN_POS:
					panPosReg <= robotCfgPkg::percent_t'(pwdata_i);
				robotRegPkg::TILT_POS:
					tiltPosReg <= robotCfgPkg::percent_t'(pwdata_i);
				default:
					ctrlReg <= ctrlReg;
			endcase
		end
	end

	// Fan out to the channels
	assign leftSpeed_o = leftSpeedReg;
	assign rightSpeed_o = rightSpeedReg;
	assign panPos_o = panPosReg;
	assign tiltPos_o = tiltPosReg;
	assign motorSel_o = ctrlReg[robotRegPkg::ctrlMotorSelBit];
	assign camSel_o = ctrlReg[robotRegPkg::ctrlCamSelBit];
	assign alarm_o = ctrlReg[robotRegPkg::ctrlAlarmBit];

endmodule

//--- hdl/servoChannel.sv
`timescale 1ns/1ps

module servoChannel (
	input  logic                  OSC_FPGA,
	input  logic                  arstN_i,
	input  robotCfgPkg::percent_t setpoint_i,
	// 1 picks the generated pulse, 0 the RC receiver
	input  logic                  genSel_i,
	input  logic                  rcIn_i,
	output logic                  pulse_o
);

	robotCfgPkg::pulseWidth_t convWidth;
	robotCfgPkg::pulseWidth_t activeWidth;
	robotCfgPkg::pulseWidth_t frameCount;
	logic frameEnd;
	logic genPulse;

	// ------------------------------
	// Percent to cycles
	// ------------------------------
	always_ff @(posedge OSC_FPGA or negedge arstN_i)
	begin
		if (!arstN_i)
		begin
			convWidth <= robotCfgPkg::pulseRestWidth;
		end
		else
		begin
			// Low limit plus percent times step
			convWidth <= robotCfgPkg::pulseLowLimit
				+ robotCfgPkg::pulseWidth_t'(setpoint_i) * robotCfgPkg::pulseRangeStep;
		end
	end

	// ------------------------------
	// Frame counter
	// ------------------------------
	assign frameEnd = (frameCount == robotCfgPkg::framePeriodCycles - 1);

	always_ff @(posedge OSC_FPGA or negedge arstN_i)
	begin
		if (!arstN_i)
		begin
			frameCount <= '0;
			activeWidth <= robotCfgPkg::pulseRestWidth;
		end
		else if (frameEnd)
		begin
			frameCount <= '0;
			// New width only at frame start, never mid pulse
			activeWidth <= convWidth;
		end
		else
		begin
			frameCount <= frameCount + 1;
		end
	end

	// High for the first activeWidth cycles of each frame
	assign genPulse = (frameCount < activeWidth);

	// Source mux, RC input passes straight through
	assign pulse_o = genSel_i ? genPulse : rcIn_i;

endmodule

//--- hdl/quadDecoder.sv
`timescale 1ns/1ps

module quadDecoder (
	input  logic                   OSC_FPGA,
	input  logic                   arstN_i,
	input  logic                   encA_i,
	input  logic                   encB_i,
	output robotCfgPkg::encCount_t count_o
);

	// Step decision per cycle
	typedef enum logic [1:0] {
		STEP_NONE,
		STEP_UP,
		STEP_DOWN
	} step_e;

	logic [1:0] syncA;
	logic [1:0] syncB;
	logic [1:0] currPair;
	logic [1:0] prevPair;
	step_e step;
	robotCfgPkg::encCount_t countReg;

	// ------------------------------
	// Input synchronizers
	// ------------------------------
	always_ff @(posedge OSC_FPGA or negedge arstN_i)
	begin
		if (!arstN_i)
		begin
			syncA <= '0;
			syncB <= '0;
			prevPair <= '0;
		end
		else
		begin
			syncA <= {syncA[0], encA_i};
			syncB <= {syncB[0], encB_i};
			prevPair <= currPair;
		end
	end

	// Pair as {A, B}
	assign currPair = {syncA[1], syncB[1]};

	// Gray order 00 10 11 01 is forward
	always_comb
	begin
		case ({prevPair, currPair})
			4'b00_10, 4'b10_11, 4'b11_01, 4'b01_00:
				step = STEP_UP;
			4'b10_00, 4'b11_10, 4'b01_11, 4'b00_01:
				step = STEP_DOWN;
			// No change, or both bits moved at once
			default:
				step = STEP_NONE;
		endcase
	end

	always_ff @(posedge OSC_FPGA or negedge arstN_i)
	begin
		if (!arstN_i)
			countReg <= robotCfgPkg::encResetCount;
		else if (step == STEP_UP)
			countReg <= countReg + 1;
		else if (step == STEP_DOWN)
			countReg <= countReg - 1;
	end

	assign count_o = countReg;

endmodule

//--- hdl/motionIoTop.sv
`timescale 1ns/1ps

module motionIoTop (
	input  logic                  OSC_FPGA,
	input  logic                  arstN_i,
	// Host APB port
	input  logic                  psel_i,
	input  logic                  penable_i,
	input  logic                  pwrite_i,
	input  robotRegPkg::apbAddr_t paddr_i,
	input  robotRegPkg::regWord_t pwdata_i,
	output robotRegPkg::regWord_t prdata_o,
	output logic                  pready_o,
	output logic                  pslverr_o,
	// RC receiver channels
	input  logic                  rcLeftElev_i,
	input  logic                  rcRightAile_i,
	input  logic                  rcPanRudd_i,
	input  logic                  rcTiltThro_i,
	// Wheel encoders
	input  logic                  encLeftA_i,
	input  logic                  encLeftB_i,
	input  logic                  encRightA_i,
	input  logic                  encRightB_i,
	// Servo and alarm outputs
	output logic                  motorLeft_o,
	output logic                  motorRight_o,
	output logic                  camPan_o,
	output logic                  camTilt_o,
	output logic                  alarm_o
);

	robotCfgPkg::percent_t leftSpeed;
	robotCfgPkg::percent_t rightSpeed;
	robotCfgPkg::percent_t panPos;
	robotCfgPkg::percent_t tiltPos;
	robotCfgPkg::encCount_t encLeftCount;
	robotCfgPkg::encCount_t encRightCount;
	logic motorSel;
	logic camSel;

	// ------------------------------
	// Host registers
	// ------------------------------
	hostRegs regs (
		.OSC_FPGA     (OSC_FPGA),
		.arstN_i      (arstN_i),
		.psel_i       (psel_i),
		.penable_i    (penable_i),
		.pwrite_i     (pwrite_i),
		.paddr_i      (paddr_i),
		.pwdata_i     (pwdata_i),
		.prdata_o     (prdata_o),
		.pready_o     (pready_o),
		.pslverr_o    (pslverr_o),
		.encLeft_i    (encLeftCount),
		.encRight_i   (encRightCount),
		.leftSpeed_o  (leftSpeed),
		.rightSpeed_o (rightSpeed),
		.panPos_o     (panPos),
		.tiltPos_o    (tiltPos),
		.motorSel_o   (motorSel),
		.camSel_o     (camSel),
		.alarm_o      (alarm_o)
	);

	// ------------------------------
	// Servo channels
	// ------------------------------
	// Motor pair shares one select
	servoChannel servoLeft (
		.OSC_FPGA   (OSC_FPGA),
		.arstN_i    (arstN_i),
		.setpoint_i (leftSpeed),
		.genSel_i   (motorSel),
		.rcIn_i     (rcLeftElev_i),
		.pulse_o    (motorLeft_o)
	);

	servoChannel servoRight (
		.OSC_FPGA   (OSC_FPGA),
		.arstN_i    (arstN_i),
		.setpoint_i (rightSpeed),
		.genSel_i   (motorSel),
		.rcIn_i     (rcRightAile_i),
		.pulse_o    (motorRight_o)
	);

	// Camera pair on the other select
	servoChannel servoPan (
		.OSC_FPGA   (OSC_FPGA),
		.arstN_i    (arstN_i),
		.setpoint_i (panPos),
		.genSel_i   (camSel),
		.rcIn_i     (rcPanRudd_i),
		.pulse_o    (camPan_o)
	);

	servoChannel servoTilt (
		.OSC_FPGA   (OSC_FPGA),
		.arstN_i    (arstN_i),
		.setpoint_i (tiltPos),
		.genSel_i   (camSel),
		.rcIn_i     (rcTiltThro_i),
		.pulse_o    (camTilt_o)
	);

	// ------------------------------
	// Encoder counters
	// ------------------------------
	quadDecoder decLeft (
		.OSC_FPGA (OSC_FPGA),
		.arstN_i  (arstN_i),
		.encA_i   (encLeftA_i),
		.encB_i   (encLeftB_i),
		.count_o  (encLeftCount)
	);

	quadDecoder decRight (
		.OSC_FPGA (OSC_FPGA),
		.arstN_i  (arstN_i),
		.encA_i   (encRightA_i),
		.encB_i   (encRightB_i),
		.count_o  (encRightCount)
	);

endmodule

//--- tests/tbClock.sv
`timescale 1ns/1ps

module tbClock (
	output logic clk_o,
	output logic arstN_o
);

	// 100 ns period
	localparam int halfPeriodNs = 50;
	localparam int resetCycles = 3;

	initial
	begin
		clk_o = 1'b0;
		forever #(halfPeriodNs) clk_o = ~clk_o;
	end

	// Release on a falling edge, away from the active edge
	initial
	begin
		arstN_o = 1'b0;
		repeat (resetCycles) @(posedge clk_o);
		@(negedge clk_o);
		arstN_o = 1'b1;
	end

endmodule

//--- tests/motionIoTb.sv
`timescale 1ns/1ps

module motionIoTb;

	localparam int apbTimeout = 16;
	// A bit over one servo frame
	localparam int frameTimeout = 1200000;
	localparam int resetTimeout = 20;

	logic clk;
	logic arstN;
	logic psel;
	logic penable;
	logic pwrite;
	robotRegPkg::apbAddr_t paddr;
	robotRegPkg::regWord_t pwdata;
	robotRegPkg::regWord_t prdata;
	logic pready;
	logic pslverr;
	logic rcLeftElev;
	logic rcRightAile;
	logic rcPanRudd;
	logic rcTiltThro;
	logic encLeftA;
	logic encLeftB;
	logic encRightA;
	logic encRightB;
	logic motorLeft;
	logic motorRight;
	logic camPan;
	logic camTilt;
	logic alarm;

	int checkCount = 0;
	int errorCount = 0;

	tbClock clockGen (
		.clk_o   (clk),
		.arstN_o (arstN)
	);

	motionIoTop uut (
		.OSC_FPGA      (clk),
		.arstN_i       (arstN),
		.psel_i        (psel),
		.penable_i     (penable),
		.pwrite_i      (pwrite),
		.paddr_i       (paddr),
		.pwdata_i      (pwdata),
		.prdata_o      (prdata),
		.pready_o      (pready),
		.pslverr_o     (pslverr),
		.rcLeftElev_i  (rcLeftElev),
		.rcRightAile_i (rcRightAile),
		.rcPanRudd_i   (rcPanRudd),
		.rcTiltThro_i  (rcTiltThro),
		.encLeftA_i    (encLeftA),
		.encLeftB_i    (encLeftB),
		.encRightA_i   (encRightA),
		.encRightB_i   (encRightB),
		.motorLeft_o   (motorLeft),
		.motorRight_o  (motorRight),
		.camPan_o      (camPan),
		.camTilt_o     (camTilt),
		.alarm_o       (alarm)
	);

	// ------------------------------
	// Compare tasks
	// ------------------------------
	task automatic checkWord(input string name, input robotRegPkg::regWord_t expected,
		input robotRegPkg::regWord_t actual);
		checkCount++;
		if (actual !== expected)
		begin
			$display("MISMATCH %s: expected 0x%h, actual 0x%h", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkWidth(input string name, input robotCfgPkg::pulseWidth_t expected,
		input robotCfgPkg::pulseWidth_t actual);
		checkCount++;
		if (actual !== expected)
		begin
			$display("MISMATCH %s: expected 0x%h, actual 0x%h", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected)
		begin
			$display("MISMATCH %s: expected 0x%h, actual 0x%h", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic reportFailure(input string msg);
		$display("ERROR: %s", msg);
		errorCount++;
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		$display("test %s finished, %0d errors", name, errorCount - errorsBefore);
	endtask

	// ------------------------------
	// Helpers
	// ------------------------------
	task automatic waitCycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// Servo width in cycles for a percent setpoint
	function automatic robotCfgPkg::pulseWidth_t expectedWidth(input int pct);
		return 32'd50000 + pct * 32'd250;
	endfunction

	// Channels numbered left right pan tilt
	function automatic logic channelOut(input int chan);
		case (chan)
			0: return motorLeft;
			1: return motorRight;
			2: return camPan;
			default: return camTilt;
		endcase
	endfunction

	function automatic string channelName(input int chan);
		case (chan)
			0: return "motorLeft_o";
			1: return "motorRight_o";
			2: return "camPan_o";
			default: return "camTilt_o";
		endcase
	endfunction

	function automatic robotRegPkg::apbAddr_t setpointAddr(input int chan);
		case (chan)
			0: return robotRegPkg::LEFT_SPEED;
			1: return robotRegPkg::RIGHT_SPEED;
			2: return robotRegPkg::PAN_POS;
			default: return robotRegPkg::TILT_POS;
		endcase
	endfunction

	task automatic setRc(input int chan, input logic level);
		case (chan)
			0: rcLeftElev = level;
			1: rcRightAile = level;
			2: rcPanRudd = level;
			default: rcTiltThro = level;
		endcase
	endtask

	// Forward Gray order {A, B}
	function automatic logic [1:0] grayPair(input int phase);
		case (phase)
			0: return 2'b00;
			1: return 2'b10;
			2: return 2'b11;
			default: return 2'b01;
		endcase
	endfunction

	task automatic waitForReset();
		int waitCount;
		waitCount = 0;
		while (arstN !== 1'b1 && waitCount < resetTimeout)
		begin
			@(negedge clk);
			waitCount++;
		end
		if (arstN !== 1'b1)
			reportFailure("reset was never released");
	endtask

	// ------------------------------
	// APB master
	// ------------------------------
	task automatic apbTransfer(input logic write, input robotRegPkg::apbAddr_t addr,
		input robotRegPkg::regWord_t wdata, output robotRegPkg::regWord_t rdata,
		output logic err);
		int waitCount;
		// Setup phase
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		#10;
		checkBit("pready_o in setup phase", 1'b0, pready);
		// Access phase
		@(negedge clk);
		penable = 1'b1;
		#10;
		waitCount = 0;
		while (pready !== 1'b1 && waitCount < apbTimeout)
		begin
			@(negedge clk);
			#10;
			waitCount++;
		end
		if (pready !== 1'b1)
		begin
			reportFailure($sformatf("no pready for access to 0x%h", addr));
			rdata = '0;
			err = 1'b1;
		end
		else
		begin
			if (waitCount != 0)
				reportFailure($sformatf("wait states on access to 0x%h", addr));
			rdata = prdata;
			err = pslverr;
		end
		// Write lands on the edge in between
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apbWrite(input robotRegPkg::apbAddr_t addr,
		input robotRegPkg::regWord_t wdata, output logic err);
		robotRegPkg::regWord_t unused;
		apbTransfer(1'b1, addr, wdata, unused, err);
	endtask

	task automatic apbRead(input robotRegPkg::apbAddr_t addr,
		output robotRegPkg::regWord_t rdata, output logic err);
		apbTransfer(1'b0, addr, '0, rdata, err);
	endtask

	task automatic checkRegister(input string name, input robotRegPkg::apbAddr_t addr,
		input robotRegPkg::regWord_t expected);
		robotRegPkg::regWord_t rdata;
		logic err;
		apbRead(addr, rdata, err);
		checkWord(name, expected, rdata);
		checkBit({name, " pslverr_o"}, 1'b0, err);
	endtask

	task automatic writeRegister(input robotRegPkg::apbAddr_t addr,
		input robotRegPkg::regWord_t wdata);
		logic err;
		apbWrite(addr, wdata, err);
		checkBit($sformatf("pslverr_o on write to 0x%h", addr), 1'b0, err);
	endtask

	// Counts the first whole high time after the next rise
	task automatic measurePulse(input int chan, output robotCfgPkg::pulseWidth_t width);
		int waitCount;
		logic lost;
		width = '0;
		lost = 1'b0;
		// Pulse in progress runs out first
		waitCount = 0;
		while (channelOut(chan) === 1'b1 && waitCount < frameTimeout)
		begin
			@(negedge clk);
			waitCount++;
		end
		if (channelOut(chan) === 1'b1)
			lost = 1'b1;
		// Rise marks the frame start
		waitCount = 0;
		while (!lost && channelOut(chan) !== 1'b1 && waitCount < frameTimeout)
		begin
			@(negedge clk);
			waitCount++;
		end
		if (channelOut(chan) !== 1'b1)
			lost = 1'b1;
		waitCount = 0;
		while (!lost && channelOut(chan) === 1'b1 && waitCount < frameTimeout)
		begin
			width++;
			@(negedge clk);
			waitCount++;
		end
		if (lost || channelOut(chan) === 1'b1)
			reportFailure($sformatf("no complete pulse seen on %s", channelName(chan)));
	endtask

	task automatic driveEncoder(input logic isRight, input logic forward, input int steps);
		int phase;
		int n;
		logic [1:0] pair;
		phase = 0;
		for (n = 0; n < steps; n++)
		begin
			phase = forward ? (phase + 1) % 4 : (phase + 3) % 4;
			pair = grayPair(phase);
			@(negedge clk);
			if (isRight)
			begin
				encRightA = pair[1];
				encRightB = pair[0];
			end
			else
			begin
				encLeftA = pair[1];
				encLeftB = pair[0];
			end
			// Four cycles per step
			waitCycles(3);
		end
	endtask

	// ------------------------------
	// Tests
	// ------------------------------
	task automatic testResetValues();
		int errorsBefore;
		int chan;
		errorsBefore = errorCount;
		checkRegister("CTRL", robotRegPkg::CTRL, 32'h0);
		for (chan = 0; chan < 4; chan++)
			checkRegister($sformatf("setpoint %0d", chan), setpointAddr(chan), 32'h64);
		checkRegister("BOARD_ID", robotRegPkg::BOARD_ID, 32'hDEADBEEF);
		checkRegister("ENC_LEFT", robotRegPkg::ENC_LEFT, 32'h80000000);
		checkRegister("ENC_RIGHT", robotRegPkg::ENC_RIGHT, 32'h80000000);
		checkBit("alarm_o", 1'b0, alarm);
		// RC inputs idle low and so do the outputs
		for (chan = 0; chan < 4; chan++)
			checkBit(channelName(chan), 1'b0, channelOut(chan));
		finishTest("resetValues", errorsBefore);
	endtask

	task automatic testRegisterAccess();
		int errorsBefore;
		int chan;
		robotRegPkg::regWord_t spValue[4];
		robotRegPkg::regWord_t ctrlValue;
		robotRegPkg::regWord_t rdata;
		logic err;
		errorsBefore = errorCount;
		for (chan = 0; chan < 4; chan++)
		begin
			spValue[chan] = $urandom;
			writeRegister(setpointAddr(chan), spValue[chan]);
		end
		ctrlValue = $urandom;
		writeRegister(robotRegPkg::CTRL, ctrlValue);
		checkBit("alarm_o", ctrlValue[2], alarm);
		// Unmapped and read-only accesses
		apbRead(8'h20, rdata, err);
		checkBit("pslverr_o on read of 0x20", 1'b1, err);
		apbWrite(8'h20, $urandom, err);
		checkBit("pslverr_o on write to 0x20", 1'b1, err);
		apbWrite(robotRegPkg::ENC_LEFT, 32'h12345678, err);
		checkBit("pslverr_o on write to ENC_LEFT", 1'b1, err);
		checkRegister("ENC_LEFT", robotRegPkg::ENC_LEFT, 32'h80000000);
		// Masked readback, nothing disturbed
		for (chan = 0; chan < 4; chan++)
			checkRegister($sformatf("setpoint %0d", chan), setpointAddr(chan),
				spValue[chan] & 32'hFF);
		checkRegister("CTRL", robotRegPkg::CTRL, ctrlValue & 32'h7);
		// Alarm bit alone
		writeRegister(robotRegPkg::CTRL, 32'h4);
		checkBit("alarm_o", 1'b1, alarm);
		writeRegister(robotRegPkg::CTRL, 32'h0);
		checkBit("alarm_o", 1'b0, alarm);
		// Back to rest for later tests
		for (chan = 0; chan < 4; chan++)
			writeRegister(setpointAddr(chan), 32'h64);
		finishTest("registerAccess", errorsBefore);
	endtask

	task automatic testPassthrough();
		int errorsBefore;
		int chan;
		int level;
		errorsBefore = errorCount;
		for (chan = 0; chan < 4; chan++)
		begin
			for (level = 1; level >= 0; level--)
			begin
				@(negedge clk);
				setRc(chan, level[0]);
				#1;
				checkBit(channelName(chan), level[0], channelOut(chan));
			end
		end
		finishTest("passthrough", errorsBefore);
	endtask

	task automatic testGeneratedPulses();
		int errorsBefore;
		robotCfgPkg::pulseWidth_t leftWidth;
		robotCfgPkg::pulseWidth_t rightWidth;
		robotCfgPkg::pulseWidth_t panWidth;
		robotCfgPkg::pulseWidth_t tiltWidth;
		errorsBefore = errorCount;
		writeRegister(robotRegPkg::LEFT_SPEED, 32'd0);
		writeRegister(robotRegPkg::RIGHT_SPEED, 32'd40);
		// Motor and camera selects
		writeRegister(robotRegPkg::CTRL, 32'h3);
		fork
			measurePulse(0, leftWidth);
			measurePulse(1, rightWidth);
			measurePulse(2, panWidth);
			measurePulse(3, tiltWidth);
		join
		checkWidth("motorLeft_o width", expectedWidth(0), leftWidth);
		checkWidth("motorRight_o width", expectedWidth(40), rightWidth);
		checkWidth("camPan_o width", expectedWidth(100), panWidth);
		checkWidth("camTilt_o width", expectedWidth(100), tiltWidth);
		finishTest("generatedPulses", errorsBefore);
	endtask

	task automatic testEncoders();
		int errorsBefore;
		int leftSteps;
		int rightSteps;
		errorsBefore = errorCount;
		leftSteps = ($urandom % 300) + 1;
		rightSteps = ($urandom % 300) + 1;
		driveEncoder(1'b0, 1'b1, leftSteps);
		driveEncoder(1'b1, 1'b0, rightSteps);
		// Sync stages plus count register
		waitCycles(5);
		checkRegister("ENC_LEFT", robotRegPkg::ENC_LEFT, 32'h80000000 + leftSteps);
		checkRegister("ENC_RIGHT", robotRegPkg::ENC_RIGHT, 32'h80000000 - rightSteps);
		finishTest("encoders", errorsBefore);
	endtask

	// ------------------------------
	// Run
	// ------------------------------
	initial
	begin
		int unsigned seed;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		rcLeftElev = 1'b0;
		rcRightAile = 1'b0;
		rcPanRudd = 1'b0;
		rcTiltThro = 1'b0;
		encLeftA = 1'b0;
		encLeftB = 1'b0;
		encRightA = 1'b0;
		encRightB = 1'b0;
		seed = 54;
		void'($urandom(seed));
		waitForReset();
		testResetValues();
		testRegisterAccess();
		testPassthrough();
		testGeneratedPulses();
		testEncoders();
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- motionIo.f
hdl/robotCfgPkg.sv
hdl/robotRegPkg.sv
hdl/hostRegs.sv
hdl/servoChannel.sv
hdl/quadDecoder.sv
hdl/motionIoTop.sv
tests/tbClock.sv
tests/motionIoTb.sv

//--- Bender.yml
package:
  name: motionIo

sources:
  # Packages first
  - hdl/robotCfgPkg.sv
  - hdl/robotRegPkg.sv
  # Design
  - hdl/hostRegs.sv
  - hdl/servoChannel.sv
  - hdl/quadDecoder.sv
  - hdl/motionIoTop.sv
  # Testbench
  - target: test
    files:
      - tests/tbClock.sv
      - tests/motionIoTb.sv
